// ==== reflet_peripheral.f ====
hw/reflet_periph_pkg.sv
hw/reflet_uart_pkg.sv
hw/reflet_gpio.sv
hw/reflet_timer.sv
hw/reflet_uart_tx_fifo.sv
hw/reflet_uart_tx.sv
hw/reflet_uart.sv
hw/reflet_peripheral.sv
tests/reflet_peripheral_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the peripheral testbench
set -e
cd "$(dirname "$0")"

verilator --binary -f reflet_peripheral.f \
    --top-module reflet_peripheral_tb -o reflet_peripheral_sim

# the log decides the result, so a failing run must not stop the script here
./obj_dir/reflet_peripheral_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/reflet_peripheral_tb.sv ====
`timescale 1ns/1ps

module reflet_peripheral_tb
    import reflet_periph_pkg::*;
();

    localparam logic [15:0] base_addr = 16'hFF00;
    localparam int fifo_depth = 4;
    // 1 MHz clock, 125 kBd line
    localparam int bit_cycles = 8;
    localparam int frame_cycles = 10 * bit_cycles;
    localparam logic [7:0] tmr_reload = 8'd5;
    localparam logic [7:0] st_full = 8'h01;
    localparam logic [7:0] st_empty = 8'h02;
    localparam logic [7:0] st_busy = 8'h04;
    localparam int n_ops = 20;

    typedef struct packed
    {
        logic        en;
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic [7:0]  rdata;
    } bus_op_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        enable;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic        write_en;
    logic [7:0]  data_out;
    logic [7:0]  gpi;
    logic [7:0]  gpo;
    logic        tx;
    logic        irq;
    logic [31:0] lfsr_state;
    bus_op_t     ops [n_ops];

    always #4 clk = ~clk;

    reflet_peripheral #(
        .addr_width(16),
        .base_addr(base_addr),
        .clk_freq(1_000_000),
        .baud_rate(125_000),
        .fifo_depth(fifo_depth)
    ) dut_i (
        .clk(clk),
        .arst_n(arst_n),
        .enable(enable),
        .addr(addr),
        .data_in(data_in),
        .write_en(write_en),
        .data_out(data_out),
        .gpi(gpi),
        .gpo(gpo),
        .tx(tx),
        .irq(irq)
    );

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        $display("Test FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [15:0] reg_addr(input reg_sel_t r);
        return base_addr + 16'(r);
    endfunction

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        enable = 1'b1;
        write_en = 1'b1;
        addr = a;
        data_in = d;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        @(negedge clk);
        enable = 1'b1;
        write_en = 1'b0;
        addr = a;
        data_in = '0;
        #1;
        d = data_out;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        enable = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic load_table();
        ops[0] = '{1'b1, 1'b1, reg_addr(reg_gpo), 8'hA5, 8'h00};
        ops[1] = '{1'b1, 1'b0, reg_addr(reg_gpo), 8'h00, 8'hA5};
        ops[2] = '{1'b1, 1'b1, reg_addr(reg_tmr_reload), 8'h09, 8'h00};
        ops[3] = '{1'b1, 1'b0, reg_addr(reg_tmr_reload), 8'h00, 8'h09};
        ops[4] = '{1'b1, 1'b0, reg_addr(reg_tmr_count), 8'h00, 8'h00};
        // just outside the window on both sides
        ops[5] = '{1'b1, 1'b1, base_addr - 16'd1, 8'h3C, 8'h00};
        ops[6] = '{1'b1, 1'b0, base_addr - 16'd1, 8'h00, 8'h00};
        ops[7] = '{1'b1, 1'b1, base_addr + 16'(total_size), 8'h5A, 8'h00};
        ops[8] = '{1'b1, 1'b0, base_addr + 16'(total_size), 8'h00, 8'h00};
        // outside, but the low bits alias gpo and reload
        ops[9] = '{1'b1, 1'b1, base_addr - 16'd8, 8'hC3, 8'h00};
        ops[10] = '{1'b1, 1'b0, base_addr - 16'd8, 8'h00, 8'h00};
        ops[11] = '{1'b1, 1'b1, base_addr + 16'd8 + 16'(reg_tmr_reload), 8'h66, 8'h00};
        ops[12] = '{1'b1, 1'b0, base_addr + 16'd8 + 16'(reg_tmr_reload), 8'h00, 8'h00};
        // enable low
        ops[13] = '{1'b0, 1'b1, reg_addr(reg_gpo), 8'hFF, 8'h00};
        ops[14] = '{1'b0, 1'b1, reg_addr(reg_tmr_reload), 8'h33, 8'h00};
        ops[15] = '{1'b0, 1'b0, reg_addr(reg_gpo), 8'h00, 8'h00};
        ops[16] = '{1'b1, 1'b0, reg_addr(reg_gpo), 8'h00, 8'hA5};
        ops[17] = '{1'b1, 1'b0, reg_addr(reg_tmr_reload), 8'h00, 8'h09};
        ops[18] = '{1'b1, 1'b0, reg_addr(reg_tmr_ctrl), 8'h00, 8'h00};
        ops[19] = '{1'b1, 1'b0, reg_addr(reg_tmr_count), 8'h00, 8'h00};
    endtask

    task automatic run_table();
        for (int i = 0; i < n_ops; i++)
        begin
            @(negedge clk);
            enable = ops[i].en;
            write_en = ops[i].wr;
            addr = ops[i].addr;
            data_in = ops[i].wdata;
            #1;
            if (!ops[i].wr)
            begin
                check_value($sformatf("data_out row %0d", i), data_out, ops[i].rdata);
            end
        end
        bus_idle();
    endtask

    // samples each bit at its middle
    task automatic receive_byte(output logic [7:0] b);
        int n;
        n = 0;
        b = '0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 3 * frame_cycles)
            begin
                fail_timeout("uart start bit");
            end
        end while (tx !== 1'b0);
        repeat (bit_cycles / 2) @(negedge clk);
        check_value("tx start bit", 8'(tx), 8'h00);
        for (int i = 0; i < 8; i++)
        begin
            repeat (bit_cycles) @(negedge clk);
            b[i] = tx;
        end
        repeat (bit_cycles) @(negedge clk);
        check_value("tx stop bit", 8'(tx), 8'h01);
    endtask

    initial
    begin
        logic [7:0] rd;
        logic [7:0] prev;
        logic [7:0] b;
        logic [7:0] got;
        logic [7:0] sent [fifo_depth + 2];
        logic [7:0] rx_q [$];
        int n;

        arst_n = 1'b0;
        enable = 1'b0;
        addr = '0;
        data_in = '0;
        write_en = 1'b0;
        gpi = '0;
        lfsr_state = 32'h3b104a05;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        check_value("tx", 8'(tx), 8'h01);
        check_value("irq", 8'(irq), 8'h00);
        check_value("gpo", gpo, 8'h00);
        bus_read(reg_addr(reg_uart_status), rd);
        check_value("uart status", rd, st_empty);
        bus_read(reg_addr(reg_tmr_reload), rd);
        check_value("tmr reload", rd, 8'h00);

        // gpio and window decode
        load_table();
        run_table();
        check_value("gpo", gpo, 8'hA5);
        for (int i = 0; i < 4; i++)
        begin
            random_byte(b);
            @(negedge clk);
            gpi = b;
            bus_read(reg_addr(reg_gpi), rd);
            check_value("gpi read", rd, b);
        end

        // timer period reload+1
        bus_write(reg_addr(reg_tmr_reload), tmr_reload);
        bus_write(reg_addr(reg_tmr_ctrl), 8'h05);
        bus_idle();
        n = 0;
        while (irq !== 1'b1)
        begin
            bus_idle();
            n++;
            if (n > 4 * (int'(tmr_reload) + 1))
            begin
                fail_timeout("timer irq");
            end
        end
        bus_read(reg_addr(reg_tmr_count), prev);
        check_value("count in range", 8'(prev <= tmr_reload), 8'h01);
        repeat (12)
        begin
            bus_read(reg_addr(reg_tmr_count), rd);
            check_value("tmr count", rd, (prev == tmr_reload) ? 8'h00 : prev + 8'd1);
            check_value("irq", 8'(irq), 8'h01);
            prev = rd;
        end
        bus_read(reg_addr(reg_tmr_ctrl), rd);
        check_value("tmr ctrl", rd, 8'h07);

        // clear the flag away from a wrap
        bus_write(reg_addr(reg_tmr_reload), tmr_reload);
        bus_write(reg_addr(reg_tmr_ctrl), 8'h05);
        bus_idle();
        check_value("irq after clear", 8'(irq), 8'h00);
        bus_read(reg_addr(reg_tmr_ctrl), rd);
        check_value("tmr ctrl", rd, 8'h05);
        bus_write(reg_addr(reg_tmr_ctrl), 8'h01);
        n = 0;
        do
        begin
            bus_read(reg_addr(reg_tmr_ctrl), rd);
            check_value("irq masked", 8'(irq), 8'h00);
            n++;
            if (n > 4 * (int'(tmr_reload) + 1))
            begin
                fail_timeout("timer flag");
            end
        end while (rd[1] !== 1'b1);
        check_value("tmr ctrl", rd, 8'h03);
        bus_write(reg_addr(reg_tmr_ctrl), 8'h00);
        bus_idle();

        // uart single byte
        random_byte(b);
        fork
            begin
                bus_write(reg_addr(reg_uart_data), b);
                bus_idle();
            end
            receive_byte(got);
        join
        check_value("uart byte", got, b);
        repeat (bit_cycles / 2 + 1) bus_idle();
        bus_read(reg_addr(reg_uart_status), rd);
        check_value("uart status", rd, st_empty);

        // burst, one more than the fifo holds
        for (int i = 0; i < fifo_depth + 2; i++)
        begin
            random_byte(sent[i]);
        end
        fork
            begin
                for (int i = 0; i < fifo_depth + 2; i++)
                begin
                    bus_write(reg_addr(reg_uart_data), sent[i]);
                end
                bus_read(reg_addr(reg_uart_status), rd);
                check_value("uart status", rd, st_full | st_busy);
                bus_idle();
            end
            for (int i = 0; i < fifo_depth + 1; i++)
            begin
                receive_byte(got);
                rx_q.push_back(got);
            end
        join
        for (int i = 0; i < fifo_depth + 1; i++)
        begin
            check_value($sformatf("uart byte %0d", i), rx_q[i], sent[i]);
        end
        repeat (frame_cycles)
        begin
            @(negedge clk);
            check_value("tx idle", 8'(tx), 8'h01);
        end
        bus_read(reg_addr(reg_uart_status), rd);
        check_value("uart status", rd, st_empty);
        bus_idle();

        $display("Test OK");
        $finish;
    end

endmodule

// ==== hw/reflet_peripheral.sv ====
`timescale 1ns/1ps

module reflet_peripheral
    import reflet_periph_pkg::*;
#(
    parameter int                  addr_width = 16,
    parameter logic [addr_width-1:0] base_addr = 16'hFF00,
    parameter int                  clk_freq = 1_000_000,
    parameter int                  baud_rate = 125_000,
    parameter int                  fifo_depth = 4
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [addr_width-1:0] addr,
    input  logic [word_width-1:0] data_in,
    input  logic                  write_en,
    output logic [word_width-1:0] data_out,
    input  logic [word_width-1:0] gpi,
    output logic [word_width-1:0] gpo,
    output logic                  tx,
    output logic                  irq
);

    logic                  sel;
    logic [addr_width-1:0] addr_rel;
    reg_sel_t              offset;
    logic [word_width-1:0] gpio_rdata;
    logic [word_width-1:0] timer_rdata;
    logic [word_width-1:0] uart_rdata;

    // window decode
    assign sel = enable && (addr >= base_addr) && (addr < base_addr + total_size);
    assign addr_rel = addr - base_addr;
    assign offset = reg_sel_t'(addr_rel[offset_width-1:0]);

    // unselected peripherals return zero
    assign data_out = gpio_rdata | timer_rdata | uart_rdata;

    reflet_gpio gpio_i (
        .clk(clk),
        .arst_n(arst_n),
        .sel(sel),
        .offset(offset),
        .data_in(data_in),
        .write_en(write_en),
        .rdata(gpio_rdata),
        .gpi(gpi),
        .gpo(gpo)
    );

    reflet_timer timer_i (
        .clk(clk),
        .arst_n(arst_n),
        .sel(sel),
        .offset(offset),
        .data_in(data_in),
        .write_en(write_en),
        .rdata(timer_rdata),
        .irq(irq)
    );

    reflet_uart #(
        .clk_freq(clk_freq),
        .baud_rate(baud_rate),
        .fifo_depth(fifo_depth)
    ) uart_i (
        .clk(clk),
        .arst_n(arst_n),
        .sel(sel),
        .offset(offset),
        .data_in(data_in),
        .write_en(write_en),
        .rdata(uart_rdata),
        .tx(tx)
    );

endmodule

// ==== hw/reflet_uart.sv ====
`timescale 1ns/1ps

module reflet_uart
    import reflet_periph_pkg::*;
    import reflet_uart_pkg::*;
#(
    parameter int clk_freq = 1_000_000,
    parameter int baud_rate = 125_000,
    parameter int fifo_depth = 4
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sel,
    input  reg_sel_t              offset,
    input  logic [word_width-1:0] data_in,
    input  logic                  write_en,
    output logic [word_width-1:0] rdata,
    output logic                  tx
);

    logic                      push;
    logic [uart_data_bits-1:0] push_data;
    logic                      full;
    logic                      pop;
    logic [uart_data_bits-1:0] head;
    logic                      empty;
    logic                      busy;

    // writes while full are lost
    assign push = sel && write_en && (offset == reg_uart_data) && !full;
    assign push_data = data_in[uart_data_bits-1:0];

    reflet_uart_tx_fifo #(
        .fifo_depth(fifo_depth)
    ) fifo_i (
        .clk(clk),
        .arst_n(arst_n),
        .push(push),
        .push_data(push_data),
        .full(full),
        .pop(pop),
        .head(head),
        .empty(empty)
    );

    reflet_uart_tx #(
        .clk_freq(clk_freq),
        .baud_rate(baud_rate)
    ) tx_i (
        .clk(clk),
        .arst_n(arst_n),
        .empty(empty),
        .head(head),
        .pop(pop),
        .tx(tx),
        .busy(busy)
    );

    always_comb
    begin
        rdata = '0;
        if (sel && offset == reg_uart_status)
        begin
            rdata[2:0] = {busy, empty, full};
        end
    end

endmodule

// ==== hw/reflet_uart_tx.sv ====
`timescale 1ns/1ps

module reflet_uart_tx
    import reflet_uart_pkg::*;
#(
    parameter int clk_freq = 1_000_000,
    parameter int baud_rate = 125_000
)
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      empty,
    input  logic [uart_data_bits-1:0] head,
    output logic                      pop,
    output logic                      tx,
    output logic                      busy
);

    localparam int clks_per_bit = clk_freq / baud_rate;
    localparam int cnt_width = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int idx_width = $clog2(uart_data_bits);

    tx_state_t                 state;
    logic [cnt_width-1:0]      bit_cnt;
    logic [idx_width-1:0]      bit_idx;
    logic [uart_data_bits-1:0] shift;
    logic                      bit_end;

    assign pop = (state == tx_idle) && !empty;
    assign busy = (state != tx_idle);
    assign bit_end = (bit_cnt == cnt_width'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= tx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx <= uart_stop_level;
        end
        else
        begin
            bit_cnt <= (state == tx_idle || bit_end) ? '0 : bit_cnt + 1'b1;
            case (state)
                tx_idle:
                begin
                    if (pop)
                    begin
                        state <= tx_start;
                        tx <= uart_start_level;
                    end
                end
                tx_start:
                begin
                    if (bit_end)
                    begin
                        state <= tx_data;
                        bit_idx <= '0;
                        tx <= shift[0];
                    end
                end
                tx_data:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == idx_width'(uart_data_bits - 1))
                        begin
                            state <= tx_stop;
                            tx <= uart_stop_level;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            tx <= shift[1];
                        end
                    end
                end
                tx_stop:
                begin
                    if (bit_end)
                    begin
                        state <= tx_idle;
                    end
                end
                default:
                begin
                    state <= tx_idle;
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            shift <= head;
        end
        else if (state == tx_data && bit_end)
        begin
            shift <= shift >> 1;
        end
    end

endmodule

// ==== hw/reflet_uart_tx_fifo.sv ====
`timescale 1ns/1ps

module reflet_uart_tx_fifo
    import reflet_uart_pkg::*;
#(
    parameter int fifo_depth = 4
)
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      push,
    input  logic [uart_data_bits-1:0] push_data,
    output logic                      full,
    input  logic                      pop,
    output logic [uart_data_bits-1:0] head,
    output logic                      empty
);

    localparam int idx_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

    logic [uart_data_bits-1:0] mem [fifo_depth];
    // extra msb tells a full buffer from an empty one
    logic [idx_width:0]        wr_ptr;
    logic [idx_width:0]        rd_ptr;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr[idx_width-1:0]] <= push_data;
        end
    end

    assign head = mem[rd_ptr[idx_width-1:0]];
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[idx_width] != rd_ptr[idx_width])
        && (wr_ptr[idx_width-1:0] == rd_ptr[idx_width-1:0]);

endmodule

// ==== hw/reflet_timer.sv ====
`timescale 1ns/1ps

module reflet_timer
    import reflet_periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sel,
    input  reg_sel_t              offset,
    input  logic [word_width-1:0] data_in,
    input  logic                  write_en,
    output logic [word_width-1:0] rdata,
    output logic                  irq
);

    logic                  run;
    logic                  flag;
    logic                  irq_en;
    logic [word_width-1:0] reload;
    logic [word_width-1:0] count;
    logic                  ctrl_wr;
    logic                  reload_wr;
    logic                  wrap;

    assign ctrl_wr = sel && write_en && (offset == reg_tmr_ctrl);
    assign reload_wr = sel && write_en && (offset == reg_tmr_reload);
    assign wrap = run && (count == reload);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run <= 1'b0;
            irq_en <= 1'b0;
            flag <= 1'b0;
            reload <= '0;
            count <= '0;
        end
        else
        begin
            if (ctrl_wr)
            begin
                run <= data_in[0];
                irq_en <= data_in[2];
            end
            // a wrap in the same cycle wins over the clear
            flag <= (flag && !(ctrl_wr && !data_in[1])) || wrap;
            if (reload_wr)
            begin
                reload <= data_in;
                count <= '0;
            end
            else if (wrap)
            begin
                count <= '0;
            end
            else if (run)
            begin
                count <= count + 1'b1;
            end
        end
    end

    assign irq = flag && irq_en;

    always_comb
    begin
        rdata = '0;
        if (sel)
        begin
            case (offset)
                reg_tmr_ctrl:   rdata[2:0] = {irq_en, flag, run};
                reg_tmr_reload: rdata = reload;
                reg_tmr_count:  rdata = count;
                default:        rdata = '0;
            endcase
        end
    end

endmodule

// ==== hw/reflet_gpio.sv ====
`timescale 1ns/1ps

module reflet_gpio
    import reflet_periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sel,
    input  reg_sel_t              offset,
    input  logic [word_width-1:0] data_in,
    input  logic                  write_en,
    output logic [word_width-1:0] rdata,
    input  logic [word_width-1:0] gpi,
    output logic [word_width-1:0] gpo
);

    logic gpo_wr;

    assign gpo_wr = sel && write_en && (offset == reg_gpo);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gpo <= '0;
        end
        else if (gpo_wr)
        begin
            gpo <= data_in;
        end
    end

    // pins are read back unregistered
    always_comb
    begin
        rdata = '0;
        if (sel)
        begin
            case (offset)
                reg_gpo:
                begin
                    rdata = gpo;
                end
                reg_gpi:
                begin
                    rdata = gpi;
                end
                default:
                begin
                    rdata = '0;
                end
            endcase
        end
    end

endmodule

// ==== hw/reflet_uart_pkg.sv ====
package reflet_uart_pkg;

    // 8N1 line format
    localparam int uart_data_bits = 8;
    localparam logic uart_start_level = 1'b0;
    localparam logic uart_stop_level = 1'b1;

    // serializer states
    typedef enum logic [1:0]
    {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

// ==== hw/reflet_periph_pkg.sv ====
package reflet_periph_pkg;

    // bus data width, as returned by every peripheral
    localparam int word_width = 8;

    // register window
    localparam int offset_width = 3;
    localparam int total_size = 7;

    // register offsets inside the window
    typedef enum logic [offset_width-1:0]
    {
        reg_gpo         = 3'd0,
        reg_gpi         = 3'd1,
        reg_tmr_ctrl    = 3'd2,
        reg_tmr_reload  = 3'd3,
        reg_tmr_count   = 3'd4,
        reg_uart_data   = 3'd5,
        reg_uart_status = 3'd6
    } reg_sel_t;

endpackage
